//--- Makefile
# Verilator build and run of the power calculator testbench

VERILATOR ?= verilator
TOP       ?= tb_pow_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A crash without output is logged as a failure too
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_pow_top.sv
`timescale 1ns/10ps

module tb_pow_top;

    import pow_pkg::*;

    // --------------------------------------------------
    // Run length

    localparam int reset_cycles   = 5;
    localparam int idle_cycles    = 10;
    localparam int drain_cycles   = 8;
    localparam int burst_len      = 8;
    // Reset, two idle stretches, eight single launches, one burst
    localparam int stim_cycles    = reset_cycles + 2 * idle_cycles
                                  + 8 * (1 + drain_cycles) + burst_len + drain_cycles;
    localparam int timeout_cycles = 2 * stim_cycles + 50;

    // Hex font, segments in a..g order
    localparam logic [6:0] font [16] = '{
        7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001, 7'b0110011, 7'b1011011,
        7'b1011111, 7'b1110000, 7'b1111111, 7'b1111011, 7'b1110111, 7'b0011111,
        7'b1001110, 7'b0111101, 7'b1001111, 7'b1000111
    };

    typedef struct packed {
        logic [31:0]         tick;
        logic [w_base - 1:0] base;
        pow_op_e             op;
    } launch_t;

    logic       slow_clk = 1'b0;
    logic       rst;
    logic [3:0] key;
    logic [7:0] sw;
    logic [7:0] led;
    logic [7:0] abcdefgh;
    logic [7:0] digit;

    // Reference model, updated on the falling edge
    launch_t              pending [$];
    logic [31:0]          tick;
    logic [w_shown - 1:0] shown_exp;
    logic [2:0]           scan_exp;
    logic [7:0]           led_exp;
    logic [7:0]           digit_exp;
    logic [7:0]           seg_exp;
    int                   seed;
    int                   errors      = 0;
    int                   cycle_count = 0;

    always #4 slow_clk = ~slow_clk;

    pow_top i_dut (
        .slow_clk ( slow_clk ),
        .rst      ( rst      ),
        .key      ( key      ),
        .sw       ( sw       ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    // Base to the exponent of the key code, code 00 meaning fifth power
    function automatic logic [63:0] power_of(input logic [7:0] base, input logic [1:0] code);
        logic [63:0] result;
        int          n;
        result = 64'd1;
        n      = (code == 2'b00) ? 5 : int'(code) + 1;
        for (int i = 0; i < n; i++) begin
            result = result * {56'd0, base};
        end
        return result;
    endfunction

    // Expected outputs for the cycle after the last rising edge
    task automatic update_model();
        launch_t     item;
        logic [63:0] full;
        if (rst) begin
            tick      = '0;
            shown_exp = '0;
            scan_exp  = '0;
            led_exp   = '0;
            pending.delete();
        end
        else begin
            tick         = tick + 32'd1;
            scan_exp     = scan_exp + 3'd1;
            led_exp[4:0] = {led_exp[3:0], key[0]};
            if (key[0]) begin
                item.tick = tick;
                item.base = sw;
                item.op   = pow_op_e'(key[2:1]);
                pending.push_back(item);
            end
            // Display follows five edges after the launch
            while (pending.size() > 0 && tick - pending[0].tick >= 32'd5) begin
                item         = pending.pop_front();
                full         = power_of(item.base, item.op);
                shown_exp    = full[31:0];
                led_exp[7:5] = {full > 64'hffff_ffff, item.op};
            end
        end
        digit_exp = 8'd1 << scan_exp;
        seg_exp   = {font[shown_exp[4 * int'(scan_exp) +: 4]], 1'b0};
    endtask

    task automatic next_cycle(input logic launch, input logic [7:0] base, input pow_op_e op);
        @(negedge slow_clk);
        update_model();
        key = {1'b0, op, launch};
        sw  = base;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle(1'b0, 8'h00, op_pow5);
    endtask

    task automatic launch_single(input logic [7:0] base, input pow_op_e op);
        next_cycle(1'b1, base, op);
        idle(drain_cycles);
    endtask

    // --------------------------------------------------
    // Checks

    led_check: assert property (@(posedge slow_clk) disable iff (rst) led == led_exp)
        else begin
            errors = errors + 1;
            $display("Error: led expected %h actual %h", $sampled(led_exp), $sampled(led));
        end

    digit_check: assert property (@(posedge slow_clk) disable iff (rst) digit == digit_exp)
        else begin
            errors = errors + 1;
            $display("Error: digit expected %h actual %h", $sampled(digit_exp), $sampled(digit));
        end

    seg_check: assert property (@(posedge slow_clk) disable iff (rst) abcdefgh == seg_exp)
        else begin
            errors = errors + 1;
            $display("Error: abcdefgh expected %h actual %h",
                     $sampled(seg_exp), $sampled(abcdefgh));
        end

    always @(posedge slow_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped, stimulus still going after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // Stimulus

    initial begin
        seed = 32'h9a771b67;
        rst  = 1'b1;
        key  = 4'h0;
        sw   = 8'h00;
        repeat (reset_cycles) next_cycle(1'b0, 8'h00, op_pow5);
        rst = 1'b0;
        // Zeros on every digit while the scan walks
        idle(idle_cycles);
        for (int i = 0; i < 4; i++) begin
            launch_single(8'($random(seed)), pow_op_e'(i[1:0]));
        end
        // One launch every cycle
        for (int i = 0; i < burst_len; i++) begin
            next_cycle(1'b1, 8'($random(seed)), pow_op_e'(i[1:0]));
        end
        idle(drain_cycles);
        // Wide fifth power, then results that fit
        launch_single(8'hff, op_pow5);
        launch_single(8'hff, op_pow4);
        launch_single(8'h05, op_pow5);
        launch_single(8'hff, op_square);
        idle(idle_cycles);
        @(negedge slow_clk);
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/pow_pkg.sv
verilog/pow_decode.sv
verilog/pow_execute.sv
verilog/pow_result.sv
verilog/pow_top.sv
dv/tb_pow_top.sv

//--- verilog/pow_decode.sv
`timescale 1ns/10ps

module pow_decode (
    input  logic              slow_clk,
    input  logic              rst,

    // Board inputs
    input  logic [3:0]        key,
    input  logic [7:0]        sw,

    // Launch request towards the pipeline
    output pow_pkg::pow_req_t req,
    output logic              req_valid
);

    import pow_pkg::*;

    // --------------------------------------------------
    // Launch decode

    logic     launch;
    pow_req_t launch_req;

    // Key 0 is the launch key, held level gives one launch per cycle
    assign launch = key[0];

    // Exponent code sits on key[2:1], both released means fifth power
    always_comb begin
        launch_req.op   = pow_op_e'(key[2:1]);
        launch_req.base = w_base'(sw);
    end

    // --------------------------------------------------
    // Registers

    // Strobe follows the launch key one cycle later
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            req_valid <= 1'b0;
        end
        else begin
            req_valid <= launch;
        end
    end

    // Payload only captured on a launch
    always_ff @(posedge slow_clk) begin
        if (launch) begin
            req <= launch_req;
        end
    end

endmodule

//--- verilog/pow_execute.sv
`timescale 1ns/10ps

module pow_execute (
    input  logic                slow_clk,
    input  logic                rst,

    // Launch request from decode
    input  pow_pkg::pow_req_t   req,
    input  logic                req_valid,

    // Final stage and the valid flag of every stage
    output pow_pkg::pow_stage_t out,
    output logic [3:0]          stage_valid
);

    import pow_pkg::*;

    // --------------------------------------------------
    // Exponent of each op code

    function automatic logic [2:0] op_exponent(input pow_op_e op);
        case (op)
            op_square: return 3'd2;
            op_cube:   return 3'd3;
            op_pow4:   return 3'd4;
            default:   return 3'd5;
        endcase
    endfunction

    // --------------------------------------------------
    // Pipeline storage

    // Index 0 holds stage 1, index 3 holds stage 4
    pow_stage_t stage_q [4];
    logic [3:0] valid_q;

    // Valid flags shift along with the data, no stall
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end
        else begin
            valid_q <= {valid_q[2:0], req_valid};
        end
    end

    // --------------------------------------------------
    // Stage 1, every op needs at least the square

    pow_stage_t first_d;

    always_comb begin
        first_d.op   = req.op;
        first_d.base = req.base;
        first_d.acc  = w_result'(req.base) * w_result'(req.base);
    end

    always_ff @(posedge slow_clk) begin
        if (req_valid) begin
            stage_q[0] <= first_d;
        end
    end

    // --------------------------------------------------
    // Stages 2 to 4

    // Stage k+1 multiplies once more while the exponent is still above it
    for (genvar k = 1; k < 4; k++) begin : g_stage
        pow_stage_t stage_d;
        logic       mul_en;

        assign mul_en = op_exponent(stage_q[k - 1].op) > 3'(k + 1);

        always_comb begin
            stage_d = stage_q[k - 1];
            if (mul_en) begin
                stage_d.acc = stage_q[k - 1].acc * w_result'(stage_q[k - 1].base);
            end
        end

        always_ff @(posedge slow_clk) begin
            if (valid_q[k - 1]) begin
                stage_q[k] <= stage_d;
            end
        end
    end

    // --------------------------------------------------
    // Outputs

    // acc of the last stage is base to the selected power
    assign out         = stage_q[3];
    assign stage_valid = valid_q;

endmodule

//--- verilog/pow_pkg.sv
package pow_pkg;

    // --------------------------------------------------
    // Widths

    // Base comes straight from the board switches
    localparam int w_base   = 8;

    // Fifth power of an 8-bit base needs five times the width
    localparam int w_result = 5 * w_base;

    // Display geometry, one hex nibble per digit
    localparam int n_digit  = 8;
    localparam int w_shown  = 4 * n_digit;

    // --------------------------------------------------
    // Exponent selection, encoded as read from key[2:1]

    typedef enum logic [1:0] {
        op_pow5   = 2'b00,
        op_square = 2'b01,
        op_cube   = 2'b10,
        op_pow4   = 2'b11
    } pow_op_e;

    // --------------------------------------------------
    // Pipeline payloads

    // Launch request from decode
    typedef struct packed {
        pow_op_e             op;
        logic [w_base - 1:0] base;
    } pow_req_t;

    // One stage of the multiply pipeline
    typedef struct packed {
        pow_op_e               op;
        logic [w_base   - 1:0] base;
        logic [w_result - 1:0] acc;   // partial power so far
    } pow_stage_t;

endpackage

//--- verilog/pow_result.sv
`timescale 1ns/10ps

module pow_result (
    input  logic                slow_clk,
    input  logic                rst,

    // Last pipeline stage
    input  pow_pkg::pow_stage_t out_stage,
    input  logic                out_valid,

    // Status of the value on display
    output pow_pkg::pow_op_e    shown_op,
    output logic                overflow,

    // Multiplexed seven-segment display
    output logic [7:0]          abcdefgh,
    output logic [7:0]          digit
);

    import pow_pkg::*;

    // --------------------------------------------------
    // Hold register

    logic [w_shown - 1:0] shown_value;
    logic                 wide_result;

    // Anything above the shown 32 bits means the display is truncated
    assign wide_result = |out_stage.acc[w_result - 1:w_shown];

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            shown_value <= '0;
            shown_op    <= op_pow5;
            overflow    <= 1'b0;
        end
        else if (out_valid) begin
            shown_value <= out_stage.acc[w_shown - 1:0];
            shown_op    <= out_stage.op;
            overflow    <= wide_result;
        end
    end

    // --------------------------------------------------
    // Digit scan

    logic [$clog2(n_digit) - 1:0] scan_idx;

    // One digit per cycle, wraps after the last one
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            scan_idx <= '0;
        end
        else begin
            scan_idx <= scan_idx + 1'b1;
        end
    end

    // Digit i shows nibble i
    assign digit = n_digit'(1) << scan_idx;

    // --------------------------------------------------
    // Hex font

    logic [3:0] nibble;
    logic [6:0] seg;

    assign nibble = shown_value[4 * scan_idx +: 4];

    // Segments in a..g order
    always_comb begin
        case (nibble)
            4'h0: seg = 7'b1111110;
            4'h1: seg = 7'b0110000;
            4'h2: seg = 7'b1101101;
            4'h3: seg = 7'b1111001;
            4'h4: seg = 7'b0110011;
            4'h5: seg = 7'b1011011;
            4'h6: seg = 7'b1011111;
            4'h7: seg = 7'b1110000;
            4'h8: seg = 7'b1111111;
            4'h9: seg = 7'b1111011;
            4'ha: seg = 7'b1110111;
            4'hb: seg = 7'b0011111;
            4'hc: seg = 7'b1001110;
            4'hd: seg = 7'b0111101;
            4'he: seg = 7'b1001111;
            default: seg = 7'b1000111;
        endcase
    end

    // Dot segment stays dark
    assign abcdefgh = {seg, 1'b0};

endmodule

//--- verilog/pow_top.sv
`timescale 1ns/10ps

module pow_top (
    input  logic       slow_clk,
    input  logic       rst,

    // Keys, switches, LEDs
    input  logic [3:0] key,
    input  logic [7:0] sw,
    output logic [7:0] led,

    // Seven-segment display
    output logic [7:0] abcdefgh,
    output logic [7:0] digit
);

    import pow_pkg::*;

    // --------------------------------------------------
    // Internal connections

    pow_req_t   req;
    logic       req_valid;
    pow_stage_t out;
    logic [3:0] stage_valid;
    pow_op_e    shown_op;
    logic       overflow;

    // --------------------------------------------------
    // Blocks

    pow_decode i_decode (
        .slow_clk  ( slow_clk  ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .req       ( req       ),
        .req_valid ( req_valid )
    );

    pow_execute i_execute (
        .slow_clk    ( slow_clk    ),
        .rst         ( rst         ),
        .req         ( req         ),
        .req_valid   ( req_valid   ),
        .out         ( out         ),
        .stage_valid ( stage_valid )
    );

    pow_result i_result (
        .slow_clk  ( slow_clk       ),
        .rst       ( rst            ),
        .out_stage ( out            ),
        .out_valid ( stage_valid[3] ),
        .shown_op  ( shown_op       ),
        .overflow  ( overflow       ),
        .abcdefgh  ( abcdefgh       ),
        .digit     ( digit          )
    );

    // LEDs: launch strobe, stage valids, shown op, overflow
    assign led = {overflow, shown_op, stage_valid, req_valid};

endmodule
